// File: tiger_cfg.svh
// tiger engine configuration
// boot vector, exception vector and the register that JAL writes
// shared by the branch unit, the alu and the testbench model

`ifndef TIGER_CFG_SVH
`define TIGER_CFG_SVH

// pc loaded by reset where the first fetch goes
`define TIGER_BOOT_ADDR 32'h0000_0400

// general exception entry
`define TIGER_EXC_ADDR 32'h0000_0180

// return address register for JAL
`define TIGER_LINK_REG 5'd31

`endif

// File: tiger_pkg.sv
// tiger engine shared types
// control word produced by decode, the Wishbone fetch request
// and the retire trace record seen at the core boundary

`default_nettype none

package tigerPkg;

	// branch condition selected by decode
	typedef enum logic [2:0] {
		brNone = 3'd0,	// not a conditional branch
		brEq   = 3'd1,	// rs == rt
		brNe   = 3'd2,	// rs != rt
		brLez  = 3'd3,	// rs <= 0
		brGtz  = 3'd4,	// rs > 0
		brLtz  = 3'd5,	// rs < 0
		brGez  = 3'd6	// rs >= 0
	} branchTypeT;

	// integer operation for the alu
	typedef enum logic [2:0] {
		aluAddu  = 3'd0,
		aluSubu  = 3'd1,
		aluAddiu = 3'd2,
		aluOri   = 3'd3,	// zero extended immediate
		aluLui   = 3'd4,
		aluNone  = 3'd7	// result forced to zero
	} aluOpT;

	// decoded control word of 12 bits
	typedef struct packed {
		logic       branch;		// conditional branch
		logic       jump;		// J or JAL, index target
		logic       regJump;	// JR or JALR, target in rs
		logic       link;		// write pc+8
		branchTypeT branchType;
		aluOpT      aluOp;
		logic       regWrite;	// instruction writes a register
		logic       useRd;		// dest is rd, else rt or link reg
	} controlT;

	// read only Wishbone classic request without we
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic [31:0] adr;
	} wbReqT;

	// one 71-bit record per retired instruction
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        regWrite;	// low for discarded or non writing instructions
		logic [4:0]  dest;
		logic [31:0] value;
	} retireT;

endpackage

`default_nettype wire

// File: tiger_fetch.sv
// tigerFetch
// Wishbone classic instruction fetch master
// opens the bus cycle once reset is released and keeps cyc and stb up,
// the address follows the pc from the branch unit which only moves on ack,
// so adr is steady for as long as the slave withholds ack
// the ack cycle delivers the instruction and ends the stall

`default_nettype none

module tigerFetch (
	input  wire logic         clk,
	input  wire logic         reset,
	output logic              stall,		// high while no instruction is delivered
	input  wire logic [31:0]  pc,			// address to fetch
	output logic [31:0]       instr,		// word taken in the ack cycle
	output logic              fetchDone,	// ack of an open request
	output tigerPkg::wbReqT   wbReq,
	input  wire logic [31:0]  wbDatIn,
	input  wire logic         wbAck
);

	logic busOpen;	// request active since reset release

	// bus is idle in reset and the first cycle after reset requests boot addr
	always_ff @(posedge clk) begin
		if (reset) begin
			busOpen <= 1'b0;
		end else begin
			busOpen <= 1'b1;	// held open from one instruction to the next
		end
	end

	// request held steady until ack
	always_comb begin
		wbReq.cyc = busOpen;
		wbReq.stb = busOpen;
		wbReq.adr = pc;	// pc register only moves in ack cycles
	end

	// ack outside an open cycle is ignored
	assign fetchDone = busOpen & wbAck;
	assign stall     = ~fetchDone;

	// data word is only meaningful while fetchDone is high
	assign instr = wbDatIn;

endmodule

`default_nettype wire

// File: tiger_decode.sv
// tigerDecode
// instruction word to control struct for the supported MIPS subset,
// integer ops, conditional branches and jumps
// anything not listed decodes as a no-op with no register write

`default_nettype none

module tigerDecode (
	input  wire logic [31:0]  instr,
	output tigerPkg::controlT control
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rtField;	// REGIMM sub opcode

	assign opcode  = instr[31:26];
	assign funct   = instr[5:0];
	assign rtField = instr[20:16];

	always_comb begin
		// no-op defaults
		control.branch     = 1'b0;
		control.jump       = 1'b0;
		control.regJump    = 1'b0;
		control.link       = 1'b0;
		control.branchType = tigerPkg::brNone;
		control.aluOp      = tigerPkg::aluNone;
		control.regWrite   = 1'b0;
		control.useRd      = 1'b0;

		case (opcode)
			6'h00: begin	// SPECIAL selected by funct
				case (funct)
					6'h21: begin	// ADDU
						control.aluOp    = tigerPkg::aluAddu;
						control.regWrite = 1'b1;
						control.useRd    = 1'b1;
					end
					6'h23: begin	// SUBU
						control.aluOp    = tigerPkg::aluSubu;
						control.regWrite = 1'b1;
						control.useRd    = 1'b1;
					end
					6'h08: control.regJump = 1'b1;	// JR
					6'h09: begin	// JALR linking to rd
						control.regJump  = 1'b1;
						control.link     = 1'b1;
						control.regWrite = 1'b1;
						control.useRd    = 1'b1;
					end
					default: ;
				endcase
			end
			6'h01: begin	// REGIMM without the link forms
				if (rtField == 5'd0) begin
					control.branch     = 1'b1;
					control.branchType = tigerPkg::brLtz;
				end else if (rtField == 5'd1) begin
					control.branch     = 1'b1;
					control.branchType = tigerPkg::brGez;
				end
			end
			6'h02: control.jump = 1'b1;	// J
			6'h03: begin	// JAL writing the link reg
				control.jump     = 1'b1;
				control.link     = 1'b1;
				control.regWrite = 1'b1;
			end
			6'h04: begin	// BEQ
				control.branch     = 1'b1;
				control.branchType = tigerPkg::brEq;
			end
			6'h05: begin	// BNE
				control.branch     = 1'b1;
				control.branchType = tigerPkg::brNe;
			end
			6'h06: begin	// BLEZ
				control.branch     = 1'b1;
				control.branchType = tigerPkg::brLez;
			end
			6'h07: begin	// BGTZ
				control.branch     = 1'b1;
				control.branchType = tigerPkg::brGtz;
			end
			6'h09: begin	// ADDIU
				control.aluOp    = tigerPkg::aluAddiu;
				control.regWrite = 1'b1;
			end
			6'h0d: begin	// ORI
				control.aluOp    = tigerPkg::aluOri;
				control.regWrite = 1'b1;
			end
			6'h0f: begin	// LUI
				control.aluOp    = tigerPkg::aluLui;
				control.regWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: tiger_regfile.sv
// tigerRegfile
// 32 x 32-bit general purpose registers
// two asynchronous read ports and one synchronous write port,
// register zero reads as zero whatever is written to it

`default_nettype none

module tigerRegfile (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic [4:0]  rsAddr,
	input  wire logic [4:0]  rtAddr,
	output logic [31:0]      rs,
	output logic [31:0]      rt,
	input  wire logic        we,		// already qualified by the core
	input  wire logic [4:0]  wAddr,
	input  wire logic [31:0] wData
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wAddr != 5'd0) begin
			regs[wAddr] <= wData;
		end
	end

	// r0 decoded out explicitly
	assign rs = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
	assign rt = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

`default_nettype wire

// File: tiger_alu.sv
// tigerAlu
// integer results for ADDU, SUBU, ADDIU, ORI and LUI
// and the pc+8 return address for JAL and JALR,
// also picks the destination register from rd, rt or the link reg

`default_nettype none

`include "tiger_cfg.svh"

module tigerAlu (
	input  wire logic [31:0]  instr,
	input  tigerPkg::controlT control,
	input  wire logic [31:0]  pc,		// address of this instruction
	input  wire logic [31:0]  rs,
	input  wire logic [31:0]  rt,
	output logic [4:0]        dest,
	output logic [31:0]       result
);

	logic [31:0] immSigned;
	logic [31:0] immZero;
	logic [31:0] opResult;

	assign immSigned = {{16{instr[15]}}, instr[15:0]};
	assign immZero   = {16'd0, instr[15:0]};	// ORI is a logical op

	always_comb begin
		case (control.aluOp)
			tigerPkg::aluAddu:  opResult = rs + rt;	// no overflow trap
			tigerPkg::aluSubu:  opResult = rs - rt;
			tigerPkg::aluAddiu: opResult = rs + immSigned;
			tigerPkg::aluOri:   opResult = rs | immZero;
			tigerPkg::aluLui:   opResult = {instr[15:0], 16'd0};
			default:            opResult = 32'd0;
		endcase
	end

	// return address skips the delay slot
	assign result = control.link ? pc + 32'd8 : opResult;

	// JALR links to rd, JAL to the fixed link reg, immediates to rt
	always_comb begin
		if (control.useRd) begin
			dest = instr[15:11];
		end else if (control.link) begin
			dest = `TIGER_LINK_REG;
		end else begin
			dest = instr[20:16];
		end
	end

endmodule

`default_nettype wire

// File: tiger_branch.sv
// tigerBranch
// owns the program counter
// evaluates branch conditions, computes branch and jump targets,
// tracks the delay slot and takes exceptions to the handler
// epc points at the branch when the faulting instruction is its delay slot

`default_nettype none

`include "tiger_cfg.svh"

module tigerBranch (
	input  wire logic         clk,
	input  wire logic         reset,
	input  wire logic         stall,		// no instruction this cycle
	input  wire logic         exception,	// only looked at when not stalled
	input  wire logic [31:0]  instr,
	input  tigerPkg::controlT control,
	input  wire logic [31:0]  rs,
	input  wire logic [31:0]  rt,
	output logic [31:0]       pc,			// address being fetched
	output logic [31:0]       epc,
	output logic              branchDelay	// current instruction sits in a delay slot
);

	logic [31:0] pcPlus4;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic [31:0] target;
	logic [31:0] pendingTarget;	// taken target, used after the delay slot
	logic [31:0] branchAddr;	// address of the branch that owns the slot
	logic        rsZero;
	logic        condMet;
	logic        redirect;

	assign pcPlus4      = pc + 32'd4;
	assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};	// stays in the 256MB region
	assign rsZero       = (rs == 32'd0);

	always_comb begin
		case (control.branchType)
			tigerPkg::brEq:  condMet = (rs == rt);
			tigerPkg::brNe:  condMet = (rs != rt);
			tigerPkg::brLez: condMet = rs[31] | rsZero;
			tigerPkg::brGtz: condMet = ~rs[31] & ~rsZero;
			tigerPkg::brLtz: condMet = rs[31];
			tigerPkg::brGez: condMet = ~rs[31];
			default:         condMet = 1'b0;
		endcase
	end

	// a branch inside a delay slot does not redirect
	assign redirect = ~branchDelay
		& ((control.branch & condMet) | control.jump | control.regJump);

	always_comb begin
		if (control.regJump) begin
			target = rs;
		end else if (control.jump) begin
			target = jumpTarget;
		end else begin
			target = branchTarget;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc          <= `TIGER_BOOT_ADDR;
			branchDelay <= 1'b0;
			epc         <= 32'd0;
		end else if (!stall) begin
			if (exception) begin
				// instruction discarded, pending target dropped
				epc         <= branchDelay ? branchAddr : pc;
				pc          <= `TIGER_EXC_ADDR;
				branchDelay <= 1'b0;
			end else if (branchDelay) begin
				pc          <= pendingTarget;	// slot done
				branchDelay <= 1'b0;
			end else begin
				pc          <= pcPlus4;	// next is the slot when redirecting
				branchDelay <= redirect;
			end
		end
	end

	// target and owner address of the branch whose slot comes next
	always_ff @(posedge clk) begin
		if (!stall && redirect) begin
			pendingTarget <= target;
			branchAddr    <= pc;
		end
	end

endmodule

`default_nettype wire

// File: tiger_core.sv
// tigerCore
// single issue MIPS subset engine without pipelining,
// one instruction executes in its fetch ack cycle
// write back and retire are qualified by fetchDone, an exception
// discards the instruction but still retires it with no register write

`default_nettype none

module tigerCore (
	input  wire logic         clk,
	input  wire logic         reset,
	input  wire logic         exception,
	output tigerPkg::wbReqT   wbReq,
	input  wire logic [31:0]  wbDatIn,
	input  wire logic         wbAck,
	output logic [31:0]       epc,
	output tigerPkg::retireT  retire
);

	logic              stall;
	logic [31:0]       pc;
	logic [31:0]       instr;
	logic              fetchDone;
	tigerPkg::controlT control;
	logic [31:0]       rs;
	logic [31:0]       rt;
	logic [4:0]        dest;
	logic [31:0]       result;
	logic              regWe;

	tigerFetch fetchUnit (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.pc        (pc),
		.instr     (instr),
		.fetchDone (fetchDone),
		.wbReq     (wbReq),
		.wbDatIn   (wbDatIn),
		.wbAck     (wbAck)
	);

	tigerDecode decodeUnit (
		.instr   (instr),
		.control (control)
	);

	tigerRegfile regfile (
		.clk    (clk),
		.reset  (reset),
		.rsAddr (instr[25:21]),
		.rtAddr (instr[20:16]),
		.rs     (rs),
		.rt     (rt),
		.we     (regWe),
		.wAddr  (dest),
		.wData  (result)
	);

	tigerAlu alu (
		.instr   (instr),
		.control (control),
		.pc      (pc),
		.rs      (rs),
		.rt      (rt),
		.dest    (dest),
		.result  (result)
	);

	// slot flag stays inside the branch unit
	tigerBranch branchUnit (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.exception   (exception),
		.instr       (instr),
		.control     (control),
		.rs          (rs),
		.rt          (rt),
		.pc          (pc),
		.epc         (epc),
		.branchDelay ()
	);

	// only a delivered, non excepting instruction writes
	assign regWe = fetchDone & ~exception & control.regWrite;

	assign retire = '{
		valid:    fetchDone,
		pc:       pc,
		regWrite: regWe,
		dest:     dest,
		value:    result
	};

endmodule

`default_nettype wire

// File: tiger_tb_mem.sv
// tigerTbMem
// Wishbone classic slave memory of 1024 words for the testbench
// the testbench loads programs straight into words[],
// ack comes after 0 to 3 wait cycles when randomAck is set

`default_nettype none

module tigerTbMem (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        randomAck,	// draw a wait count after each ack
	input  tigerPkg::wbReqT  wbReq,
	output logic [31:0]      wbDatIn,
	output logic             wbAck
);

	logic [31:0] words [1024];
	logic [1:0]  waitCnt;	// cycles left before the next ack
	logic [31:0] delayPool;	// fresh random word every cycle
	integer      seed;

	initial begin
		seed = 32'hf430_45a6;
		delayPool = 32'd0;
	end

	always @(posedge clk) begin
		delayPool <= $random(seed);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			waitCnt <= 2'd0;
		end else if (wbAck) begin
			waitCnt <= randomAck ? delayPool[1:0] : 2'd0;	// delay of the next request
		end else if (wbReq.cyc && waitCnt != 2'd0) begin
			waitCnt <= waitCnt - 2'd1;
		end
	end

	// ack in the first request cycle when no wait is pending
	assign wbAck   = wbReq.cyc & wbReq.stb & (waitCnt == 2'd0);
	assign wbDatIn = words[wbReq.adr[11:2]];

endmodule

`default_nettype wire

// File: tiger_checker.sv
// tigerChecker
// concurrent assertions on the fetch handshake and the reset state,
// bound into every tigerCore instance

`default_nettype none

module tigerChecker (
	input wire logic        clk,
	input wire logic        reset,
	input tigerPkg::wbReqT  wbReq,
	input wire logic        wbAck,
	input tigerPkg::retireT retire
);

	// request held until the slave acks
	holdRequest: assert property (@(posedge clk) disable iff (reset)
		(wbReq.cyc && wbReq.stb && !wbAck) |=> ($stable(wbReq.adr) && wbReq.stb))
		else $error("fetch request changed while ack was low");

	// one edge into reset the bus is idle and nothing retires
	idleInReset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> (!wbReq.cyc && !retire.valid))
		else $error("bus active or retire valid during reset");

	// retire in exactly the ack cycles of an open request
	retireOnAck: assert property (@(posedge clk)
		retire.valid == (wbReq.cyc && wbReq.stb && wbAck))
		else $error("retire valid does not match the fetch ack");

endmodule

bind tigerCore tigerChecker coreChecker (
	.clk    (clk),
	.reset  (reset),
	.wbReq  (wbReq),
	.wbAck  (wbAck),
	.retire (retire)
);

`default_nettype wire

// File: tiger_tb.sv
// tigerTb
// directed tests for the tiger engine covering integer ops, branches,
// jumps with links, exception entry and Wishbone back-pressure
// every retire is compared with a small instruction-level model

`default_nettype none

`include "tiger_cfg.svh"

module tigerTb;

	logic             clk;
	logic             reset;
	logic             exception;
	logic             randomAck;
	tigerPkg::wbReqT  wbReq;
	logic [31:0]      wbDatIn;
	logic             wbAck;
	logic [31:0]      epc;
	tigerPkg::retireT retire;

	// model state
	logic [31:0] mRegs [32];
	logic [31:0] mPc;
	logic [31:0] mPend;	// target after the slot
	logic [31:0] mBranchAddr;
	logic [31:0] mEpc;
	logic        mDelay;

	tigerPkg::retireT trace [64];	// last run
	tigerPkg::retireT refTrace [64];

	tigerCore uut (
		.clk       (clk),
		.reset     (reset),
		.exception (exception),
		.wbReq     (wbReq),
		.wbDatIn   (wbDatIn),
		.wbAck     (wbAck),
		.epc       (epc),
		.retire    (retire)
	);

	tigerTbMem memory (
		.clk       (clk),
		.reset     (reset),
		.randomAck (randomAck),
		.wbReq     (wbReq),
		.wbDatIn   (wbDatIn),
		.wbAck     (wbAck)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] encI(int op, int rs, int rt, int imm);
		return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] encR(int funct, int rs, int rt, int rd);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct[5:0]};
	endfunction

	function automatic logic [31:0] encJ(int op, int addr);
		return {op[5:0], addr[27:2]};
	endfunction

	task automatic putWord(input int addr, input logic [31:0] w);
		memory.words[addr[11:2]] = w;
	endtask

	// opcode 3f is unused, so the fill retires as no-ops
	task automatic clearMemory();
		for (int i = 0; i < 1024; i++) begin
			memory.words[i] = {6'h3f, 16'h0000, i[9:0]};
		end
	endtask

	task automatic checkValue(input string testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s %s expected %h actual %h", testName, what, expected, actual);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic modelReset();
		for (int i = 0; i < 32; i++) begin
			mRegs[i] = 32'd0;
		end
		mPc = `TIGER_BOOT_ADDR;
		mPend = 32'd0;
		mBranchAddr = 32'd0;
		mEpc = 32'd0;
		mDelay = 1'b0;
	endtask

	// one instruction of the reference model
	task automatic modelStep(input logic exc, output tigerPkg::retireT r);
		logic [31:0] instr;
		logic [31:0] rsV;
		logic [31:0] rtV;
		logic [31:0] pc4;
		logic [31:0] tgt;
		logic [31:0] val;
		logic [4:0]  dst;
		logic        wr;
		logic        taken;
		instr = memory.words[mPc[11:2]];
		rsV = mRegs[instr[25:21]];
		rtV = mRegs[instr[20:16]];
		pc4 = mPc + 32'd4;
		tgt = pc4 + {{14{instr[15]}}, instr[15:0], 2'b00};	// conditional target
		val = 32'd0;
		dst = instr[20:16];
		wr = 1'b0;
		taken = 1'b0;
		case (instr[31:26])
			6'h00: begin
				dst = instr[15:11];
				case (instr[5:0])
					6'h21: begin
						val = rsV + rtV;
						wr = 1'b1;
					end
					6'h23: begin
						val = rsV - rtV;
						wr = 1'b1;
					end
					6'h08: begin
						taken = 1'b1;
						tgt = rsV;
					end
					6'h09: begin
						taken = 1'b1;
						tgt = rsV;
						val = mPc + 32'd8;
						wr = 1'b1;
					end
					default: ;
				endcase
			end
			6'h01: taken = (instr[20:16] == 5'd0) ? rsV[31] : (instr[20:16] == 5'd1) && !rsV[31];
			6'h02: begin
				taken = 1'b1;
				tgt = {pc4[31:28], instr[25:0], 2'b00};
			end
			6'h03: begin
				taken = 1'b1;
				tgt = {pc4[31:28], instr[25:0], 2'b00};
				val = mPc + 32'd8;
				dst = `TIGER_LINK_REG;
				wr = 1'b1;
			end
			6'h04: taken = (rsV == rtV);
			6'h05: taken = (rsV != rtV);
			6'h06: taken = rsV[31] || rsV == 32'd0;
			6'h07: taken = !rsV[31] && rsV != 32'd0;
			6'h09: begin
				val = rsV + {{16{instr[15]}}, instr[15:0]};
				wr = 1'b1;
			end
			6'h0d: begin
				val = rsV | {16'd0, instr[15:0]};
				wr = 1'b1;
			end
			6'h0f: begin
				val = {instr[15:0], 16'd0};
				wr = 1'b1;
			end
			default: ;
		endcase
		r = '{valid: 1'b1, pc: mPc, regWrite: wr & ~exc, dest: dst, value: val};
		if (exc) begin
			mEpc = mDelay ? mBranchAddr : mPc;	// slot faults blame the branch
			mPc = `TIGER_EXC_ADDR;
			mDelay = 1'b0;
		end else begin
			if (wr && dst != 5'd0) mRegs[dst] = val;
			if (mDelay) begin
				mPc = mPend;
				mDelay = 1'b0;
			end else begin
				if (taken) begin
					mPend = tgt;
					mBranchAddr = mPc;
					mDelay = 1'b1;
				end
				mPc = pc4;
			end
		end
	endtask

	// reset the core, then check count retires; excIdx picks the faulting one
	task automatic runProgram(input string name, input int count, input int excIdx,
		input logic randomDelay);
		int cnt;
		tigerPkg::retireT got;
		tigerPkg::retireT exp;
		modelReset();
		@(posedge clk);
		reset <= 1'b1;
		randomAck <= randomDelay;
		exception <= (excIdx == 0);
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < count; i++) begin
			cnt = 0;
			@(negedge clk);
			while (!retire.valid) begin
				cnt++;
				if (cnt > 20) begin
					$display("%s: no instruction retired within 20 cycles", name);
					$display("Checks failed");
					$fatal(1);
				end else begin
					@(negedge clk);
				end
			end
			got = retire;
			trace[i] = got;
			modelStep(i == excIdx, exp);
			checkValue(name, "pc", exp.pc, got.pc);
			checkValue(name, "adr", exp.pc, wbReq.adr);
			checkValue(name, "regWrite", {31'd0, exp.regWrite}, {31'd0, got.regWrite});
			if (exp.regWrite) begin
				checkValue(name, "dest", {27'd0, exp.dest}, {27'd0, got.dest});
				checkValue(name, "value", exp.value, got.value);
			end
			@(posedge clk);
			exception <= (i + 1 == excIdx);
		end
		@(negedge clk);
		checkValue(name, "epc", mEpc, epc);
	endtask

	task automatic integerTest();
		clearMemory();
		putWord(32'h400, encI('h0f, 0, 1, 'h1234));	// lui r1
		putWord(32'h404, encI('h0d, 1, 1, 'h5678));	// ori r1
		putWord(32'h408, encI('h09, 0, 2, -3));
		putWord(32'h40c, encR('h21, 1, 2, 3));
		putWord(32'h410, encR('h23, 2, 1, 4));
		putWord(32'h414, encI('h09, 0, 0, 5));	// r0 must stay zero
		putWord(32'h418, encR('h21, 0, 2, 5));
		runProgram("integer", 8, -1, 1'b0);
	endtask

	// a branch whose slot bumps r10 and whose skipped word bumps r11
	task automatic putBranch(inout int addr, input logic [31:0] br);
		putWord(addr, br);
		putWord(addr + 4, encI('h09, 10, 10, 1));
		putWord(addr + 8, encI('h09, 11, 11, 1));
		addr = addr + 12;
	endtask

	task automatic loadBranches();
		int a;
		clearMemory();
		putWord(32'h400, encI('h09, 0, 1, -5));
		putWord(32'h404, encI('h09, 0, 2, 7));
		a = 32'h408;
		putBranch(a, encI('h04, 1, 1, 2));
		putBranch(a, encI('h04, 1, 2, 2));
		putBranch(a, encI('h05, 1, 2, 2));
		putBranch(a, encI('h05, 2, 2, 2));
		putBranch(a, encI('h06, 1, 0, 2));
		putBranch(a, encI('h06, 0, 0, 2));
		putBranch(a, encI('h06, 2, 0, 2));
		putBranch(a, encI('h07, 2, 0, 2));
		putBranch(a, encI('h07, 0, 0, 2));
		putBranch(a, encI('h01, 1, 0, 2));	// bltz
		putBranch(a, encI('h01, 0, 0, 2));
		putBranch(a, encI('h01, 0, 1, 2));	// bgez
		putBranch(a, encI('h01, 1, 1, 2));
		putWord(a, encR('h21, 10, 11, 12));
	endtask

	task automatic jumpTest();
		clearMemory();
		putWord(32'h400, encJ('h03, 32'h420));	// jal
		putWord(32'h404, encI('h09, 0, 1, 1));
		putWord(32'h420, encI('h09, 0, 2, 32'h440));
		putWord(32'h424, encR('h08, 2, 0, 0));	// jr r2
		putWord(32'h428, encI('h09, 0, 3, 3));
		putWord(32'h440, encI('h09, 0, 4, 32'h460));
		putWord(32'h444, encR('h09, 4, 0, 5));	// jalr r5, r4
		putWord(32'h448, encR('h21, 31, 0, 6));
		putWord(32'h460, encJ('h02, 32'h480));
		putWord(32'h464, encI('h09, 5, 7, 1));
		putWord(32'h480, encR('h21, 5, 0, 7));
		runProgram("jumps", 12, -1, 1'b0);
	endtask

	task automatic exceptionTest();
		clearMemory();
		putWord(32'h400, encI('h09, 0, 1, 1));
		putWord(32'h404, encI('h09, 0, 2, 2));	// faults
		putWord(`TIGER_EXC_ADDR, encI('h09, 0, 3, 3));
		runProgram("exception", 4, 1, 1'b0);
		clearMemory();
		putWord(32'h400, encI('h04, 0, 0, 3));	// taken to 0x410
		putWord(32'h404, encI('h09, 0, 4, 4));	// slot faults
		putWord(32'h410, encI('h09, 0, 5, 5));
		putWord(`TIGER_EXC_ADDR, encI('h09, 0, 3, 3));
		runProgram("exception in slot", 4, 1, 1'b0);
	endtask

	task automatic backPressureTest();
		loadBranches();
		runProgram("no delay", 35, -1, 1'b0);
		for (int i = 0; i < 35; i++) begin
			refTrace[i] = trace[i];
		end
		runProgram("random delay", 35, -1, 1'b1);
		for (int i = 0; i < 35; i++) begin
			checkValue("back-pressure", "pc", refTrace[i].pc, trace[i].pc);
			checkValue("back-pressure", "dest",
				{27'd0, refTrace[i].dest}, {27'd0, trace[i].dest});
			checkValue("back-pressure", "value", refTrace[i].value, trace[i].value);
		end
	endtask

	initial begin
		reset = 1'b1;
		exception = 1'b0;
		randomAck = 1'b0;
		integerTest();
		loadBranches();
		runProgram("branches", 35, -1, 1'b0);
		jumpTest();
		exceptionTest();
		backPressureTest();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
tiger_pkg.sv
tiger_fetch.sv
tiger_decode.sv
tiger_regfile.sv
tiger_alu.sv
tiger_branch.sv
tiger_core.sv
tiger_tb_mem.sv
tiger_checker.sv
tiger_tb.sv

// File: run.sh
#!/bin/sh
# build and run the tiger engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tigerTb -o tigerSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tigerSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
	exit 0
else
	exit 1
fi
